// ==== files.f ====
clock_pkg.sv
btn_sync.sv
clock_ctrl.sv
time_keeper.sv
digit_encode.sv
disp_scan.sv
clock_top.sv
clock_chk.sv
tb_clock.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the digital clock testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_clock -f files.f -o sim_clock \
	&& ./obj_dir/sim_clock > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "No pass result in log"; exit 1; }
exit 0

// ==== tb_clock.sv ====
// ----------------------------
// Digital clock testbench
// Random button presses against a cycle model,
// display, dp and alarm compared every cycle
// ----------------------------
module tb_clock import clock_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int B_MODE = 0;
	localparam int B_POS = 1;
	localparam int B_INC = 2;
	localparam int B_ALARM = 3;
	localparam int PRESS_CYC = 14; // Start edge, longest hold and longest release
	localparam int MAX_PRESS = 320;
	localparam int WAIT_CYC = 60 + 100 * TICKS_PER_SEC + 40;
	localparam int LIMIT = 3 * (PRESS_CYC * MAX_PRESS + WAIT_CYC) / 2;

	logic clk, rst_n;
	logic [3:0] btn; // {alarm, inc, pos, mode}
	seg_t o_seg;
	digit_sel_t o_seg_enb;
	logic o_seg_dp, o_alarm;

	// Model state
	logic [3:0] s1, s2, s3, pl;
	mode_e m_mode;
	pos_e m_pos;
	logic m_en, m_alarm;
	field_t t_inc, a_inc;
	logic [3:0] m_div;
	hms_t m_sec, m_min, m_hou, a_sec, a_min, a_hou;
	logic [1:0] m_sc;
	logic [2:0] m_idx;
	digit_sel_t m_enb;

	int err_seg, err_enb, err_dp, err_alarm, cycles, stable;
	logic [21:0] prev_key;

	clock_top i_dut (
		.i_btn_mode(btn[0]), .i_btn_pos(btn[1]), .i_btn_inc(btn[2]), .i_btn_alarm(btn[3]),
		.o_seg(o_seg), .o_seg_enb(o_seg_enb), .o_seg_dp(o_seg_dp), .o_alarm(o_alarm),
		.clk(clk), .rst_n(rst_n));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic hms_t next_value(input hms_t v, input hms_t lim);
		return (v == lim) ? 6'd0 : v + 6'd1;
	endfunction

	function automatic seg_t seg_pattern(input int d);
		case (d)
			0: return 7'h7e;
			1: return 7'h30;
			2: return 7'h6d;
			3: return 7'h79;
			4: return 7'h33;
			5: return 7'h5b;
			6: return 7'h5f;
			7: return 7'h70;
			8: return 7'h7f;
			9: return 7'h73;
			default: return 7'h00;
		endcase
	endfunction

	// Digit number from the enable pins, -1 when not exactly one is low
	function automatic int enb_index(input digit_sel_t enb);
		int idx;
		int cnt;
		idx = -1;
		cnt = 0;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			if (!enb[i]) begin
				idx = i;
				cnt++;
			end
		end
		return (cnt == 1) ? idx : -1;
	endfunction

	// ----------------------------
	// Cycle model
	// ----------------------------
	always @(posedge clk or negedge rst_n) begin : model
		logic tick;
		if (!rst_n) begin
			{s1, s2, s3, pl} <= '0;
			m_mode <= MODE_CLOCK;
			m_pos <= POS_SEC;
			{m_en, m_alarm, t_inc, a_inc, m_div} <= '0;
			{m_sec, m_min, m_hou, a_sec, a_min, a_hou} <= '0;
			m_sc <= '0;
			m_idx <= '0;
			m_enb <= '1;
		end else begin
			tick = (m_mode != MODE_SETUP) && (m_div == 4'(TICKS_PER_SEC - 1));
			s1 <= btn;
			s2 <= s1;
			s3 <= s2;
			pl <= s2 & ~s3;
			if (pl[B_MODE])
				m_mode <= (m_mode == MODE_CLOCK) ? MODE_SETUP :
					(m_mode == MODE_SETUP) ? MODE_ALARM : MODE_CLOCK;
			if (pl[B_POS])
				m_pos <= (m_pos == POS_SEC) ? POS_MIN : (m_pos == POS_MIN) ? POS_HOU : POS_SEC;
			if (pl[B_ALARM])
				m_en <= !m_en;
			t_inc <= (pl[B_INC] && m_mode == MODE_SETUP) ? field_t'(1) << m_pos : '0;
			a_inc <= (pl[B_INC] && m_mode == MODE_ALARM) ? field_t'(1) << m_pos : '0;
			if (tick)
				m_div <= '0;
			else if (m_mode != MODE_SETUP)
				m_div <= m_div + 4'd1;
			if (tick) begin // Carry chain
				m_sec <= next_value(m_sec, 6'd59);
				if (m_sec == 6'd59) begin
					m_min <= next_value(m_min, 6'd59);
					if (m_min == 6'd59)
						m_hou <= next_value(m_hou, 6'd23);
				end
			end
			if (t_inc[0]) m_sec <= next_value(m_sec, 6'd59);
			if (t_inc[1]) m_min <= next_value(m_min, 6'd59);
			if (t_inc[2]) m_hou <= next_value(m_hou, 6'd23);
			if (a_inc[0]) a_sec <= next_value(a_sec, 6'd59);
			if (a_inc[1]) a_min <= next_value(a_min, 6'd59);
			if (a_inc[2]) a_hou <= next_value(a_hou, 6'd23);
			m_alarm <= m_en && (m_alarm ||
				(m_sec == a_sec && m_min == a_min && m_hou == a_hou));
			m_sc <= m_sc + 2'd1; // Scan divider of four
			if (m_sc == 2'd3)
				m_idx <= (m_idx == 3'd5) ? 3'd0 : m_idx + 3'd1;
			m_enb <= ~(digit_sel_t'(1) << m_idx);
		end
	end

	// ----------------------------
	// Compare tasks
	// ----------------------------
	task automatic check_seg(input seg_t got, input seg_t exp);
		if (got !== exp) begin
			err_seg++;
			$display("Fail o_seg: got %h expected %h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_enb(input digit_sel_t got, input digit_sel_t exp);
		if (got !== exp) begin
			err_enb++;
			$display("Fail o_seg_enb: got %h expected %h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_dp(input logic got, input logic exp);
		if (got !== exp) begin
			err_dp++;
			$display("Fail o_seg_dp: got %h expected %h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_alarm(input logic got, input logic exp);
		if (got !== exp) begin
			err_alarm++;
			$display("Fail o_alarm: got %h expected %h at %0t", got, exp, $time);
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin : compare
		logic [21:0] key;
		hms_t f;
		int idx;
		logic dp;
		if (rst_n) begin
			key = m_mode == MODE_ALARM ? {m_mode, m_pos, a_sec, a_min, a_hou}
				: {m_mode, m_pos, m_sec, m_min, m_hou};
			stable = (key == prev_key) ? stable + 1 : 0;
			prev_key = key;
			check_enb(o_seg_enb, m_enb);
			check_alarm(o_alarm, m_alarm);
			idx = enb_index(o_seg_enb);
			if (stable >= 2 && idx >= 0) begin
				case (idx / 2)
					0: f = (m_mode == MODE_ALARM) ? a_sec : m_sec;
					1: f = (m_mode == MODE_ALARM) ? a_min : m_min;
					default: f = (m_mode == MODE_ALARM) ? a_hou : m_hou;
				endcase
				dp = (m_mode == MODE_SETUP && idx == 2 * int'(m_pos)) ||
					(m_mode == MODE_ALARM && idx == 2 * int'(m_pos) + 1);
				check_seg(o_seg, seg_pattern((idx % 2) ? int'(f) / 10 : int'(f) % 10));
				check_dp(o_seg_dp, dp);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

	// ----------------------------
	// Stimulus
	// ----------------------------
	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic press(input int b);
		@(negedge clk);
		btn[b] = 1'b1;
		wait_cycles(3 + $urandom % 4);
		btn[b] = 1'b0;
		wait_cycles(4 + $urandom % 4);
	endtask

	task automatic press_times(input int b, input int n);
		repeat (n) press(b);
	endtask

	initial begin
		btn = '0;
		rst_n = 1'b0;
		err_seg = 0;
		err_enb = 0;
		err_dp = 0;
		err_alarm = 0;
		cycles = 0;
		stable = 0;
		prev_key = '0;
		void'($urandom(13220));
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		wait_cycles(60);                // Reset display, then free running
		press(B_MODE);                  // Setup, each field wraps once on the way to 23:59:5x
		press_times(B_INC, (50 + int'($urandom % 10) + 60 - int'(m_sec)) % 60 + 60);
		press(B_POS);
		press_times(B_INC, (59 + 60 - int'(m_min)) % 60 + 60);
		press(B_POS);
		press_times(B_INC, (23 + 24 - int'(m_hou)) % 24 + 24); // Full wrap of hours
		press(B_MODE);                  // Alarm mode, time keeps running
		press(B_POS);
		press_times(B_INC, $urandom % 10);
		press(B_POS);
		press(B_INC);                   // Alarm at 00:01:0k
		press(B_MODE);
		press(B_ALARM);
		while (!m_alarm)
			@(negedge clk);
		wait_cycles(20);
		press(B_ALARM);                 // Disable clears the flag
		wait_cycles(10);
		$display("Errors: seg=%0d enb=%0d dp=%0d alarm=%0d", err_seg, err_enb, err_dp, err_alarm);
		if (err_seg + err_enb + err_dp + err_alarm == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== clock_chk.sv ====
// ----------------------------
// Display and alarm checker
// Bound to the clock top level
// ----------------------------
module clock_chk import clock_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input digit_sel_t i_seg_enb,
	input logic       i_seg_dp,
	input logic       i_alarm,
	input logic       i_alarm_en
);
	timeunit 1ns;
	timeprecision 1ps;

	// At most one digit lit
	enb_one_low: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~i_seg_enb) || (i_seg_enb == '1))
		else $error("o_seg_enb has more than one digit enabled");

	dp_needs_digit: assert property (@(posedge clk) disable iff (!rst_n)
		i_seg_dp |-> (i_seg_enb != '1))
		else $error("o_seg_dp high with no digit enabled");

	// Flag only sets from an enabled alarm
	alarm_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(i_alarm) |-> $past(i_alarm_en))
		else $error("o_alarm rose while the alarm was disabled");

endmodule

bind clock_top clock_chk u_clock_chk (
	.clk(clk), .rst_n(rst_n), .i_seg_enb(o_seg_enb), .i_seg_dp(o_seg_dp),
	.i_alarm(o_alarm), .i_alarm_en(alarm_en));

// ==== clock_top.sv ====
// ----------------------------
// Digital clock top
// Buttons, control, time keeping, encoding, scan
// ----------------------------
module clock_top import clock_pkg::*; (
	input  logic       i_btn_mode,
	input  logic       i_btn_pos,
	input  logic       i_btn_inc,
	input  logic       i_btn_alarm,
	output seg_t       o_seg,
	output digit_sel_t o_seg_enb,
	output logic       o_seg_dp,
	output logic       o_alarm,
	input  logic       clk,
	input  logic       rst_n
);

	logic mode_pulse, pos_pulse, inc_pulse, alarm_pulse;
	logic run, alarm_en, show_alarm;
	field_t time_inc, alarm_inc;
	dp_mask_t dp_mask;
	hms_t sec, min, hou;
	hms_t alarm_sec, alarm_min, alarm_hou;
	seg_t [NUM_DIGITS-1:0] seg_digits;

	btn_sync u_btn_sync (
		.i_btn_mode(i_btn_mode), .i_btn_pos(i_btn_pos),
		.i_btn_inc(i_btn_inc), .i_btn_alarm(i_btn_alarm),
		.o_mode_pulse(mode_pulse), .o_pos_pulse(pos_pulse),
		.o_inc_pulse(inc_pulse), .o_alarm_pulse(alarm_pulse),
		.clk(clk), .rst_n(rst_n));

	clock_ctrl u_clock_ctrl (
		.i_mode_pulse(mode_pulse), .i_pos_pulse(pos_pulse),
		.i_inc_pulse(inc_pulse), .i_alarm_pulse(alarm_pulse),
		.o_run(run), .o_time_inc(time_inc), .o_alarm_inc(alarm_inc),
		.o_alarm_en(alarm_en), .o_show_alarm(show_alarm), .o_dp_mask(dp_mask),
		.clk(clk), .rst_n(rst_n));

	time_keeper u_time_keeper (
		.i_run(run), .i_time_inc(time_inc), .i_alarm_inc(alarm_inc),
		.i_alarm_en(alarm_en), .o_sec(sec), .o_min(min), .o_hou(hou),
		.o_alarm_sec(alarm_sec), .o_alarm_min(alarm_min), .o_alarm_hou(alarm_hou),
		.o_alarm(o_alarm), .clk(clk), .rst_n(rst_n));

	digit_encode u_digit_encode (
		.i_show_alarm(show_alarm), .i_sec(sec), .i_min(min), .i_hou(hou),
		.i_alarm_sec(alarm_sec), .i_alarm_min(alarm_min), .i_alarm_hou(alarm_hou),
		.o_seg_digits(seg_digits));

	disp_scan u_disp_scan (
		.i_seg_digits(seg_digits), .i_dp_mask(dp_mask),
		.o_seg(o_seg), .o_seg_enb(o_seg_enb), .o_seg_dp(o_seg_dp),
		.clk(clk), .rst_n(rst_n));

endmodule

// ==== disp_scan.sv ====
// ----------------------------
// Display scan stage
// Steps through the six digits and registers
// the active digit's segments, enable and dp
// ----------------------------
module disp_scan import clock_pkg::*; (
	input  seg_t [NUM_DIGITS-1:0] i_seg_digits,
	input  dp_mask_t              i_dp_mask,
	output seg_t                  o_seg,
	output digit_sel_t            o_seg_enb,
	output logic                  o_seg_dp,
	input  logic                  clk,
	input  logic                  rst_n
);

	localparam int SCAN_W = $clog2(SCAN_TICKS);
	localparam int IDX_W  = $clog2(NUM_DIGITS);
	localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_TICKS - 1);
	localparam logic [IDX_W-1:0]  IDX_LAST  = IDX_W'(NUM_DIGITS - 1);

	logic [SCAN_W-1:0] scan_cnt;
	logic [IDX_W-1:0]  idx;      // Active digit, 0 = seconds ones

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_cnt <= '0;
			idx      <= '0;
		end else if (scan_cnt == SCAN_LAST) begin
			scan_cnt <= '0;
			idx      <= (idx == IDX_LAST) ? '0 : idx + 1'b1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// Output pins, one cycle behind the index
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= '0;
			o_seg_enb <= '1; // No digit lit
			o_seg_dp  <= 1'b0;
		end else begin
			o_seg     <= i_seg_digits[idx];
			o_seg_enb <= ~(digit_sel_t'(1) << idx);
			o_seg_dp  <= i_dp_mask[idx];
		end
	end

endmodule

// ==== digit_encode.sv ====
// ----------------------------
// Digit encoding stage
// Picks time or alarm fields, splits them into
// tens and ones, encodes seven-segment patterns
// ----------------------------
module digit_encode import clock_pkg::*; (
	input  logic                  i_show_alarm,
	input  hms_t                  i_sec,
	input  hms_t                  i_min,
	input  hms_t                  i_hou,
	input  hms_t                  i_alarm_sec,
	input  hms_t                  i_alarm_min,
	input  hms_t                  i_alarm_hou,
	output seg_t [NUM_DIGITS-1:0] o_seg_digits // Digit 0 is seconds ones
);

	hms_t fld [3]; // sec, min, hou as displayed

	// Blank for anything past 9
	function automatic seg_t seg_of(input bcd_t d);
		return (d < 4'd10) ? SEG_DIGIT[d] : '0;
	endfunction

	assign fld[0] = i_show_alarm ? i_alarm_sec : i_sec;
	assign fld[1] = i_show_alarm ? i_alarm_min : i_min;
	assign fld[2] = i_show_alarm ? i_alarm_hou : i_hou;

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			o_seg_digits[2*i]   = seg_of(bcd_t'(fld[i] % 6'd10)); // Ones
			o_seg_digits[2*i+1] = seg_of(bcd_t'(fld[i] / 6'd10)); // Tens
		end
	end

endmodule

// ==== time_keeper.sv ====
// ----------------------------
// Time keeping stage
// Seconds tick divider, hh:mm:ss counters with carry,
// alarm counters and the alarm match flag
// ----------------------------
module time_keeper import clock_pkg::*; (
	input  logic   i_run,
	input  field_t i_time_inc,
	input  field_t i_alarm_inc,
	input  logic   i_alarm_en,
	output hms_t   o_sec,
	output hms_t   o_min,
	output hms_t   o_hou,
	output hms_t   o_alarm_sec,
	output hms_t   o_alarm_min,
	output hms_t   o_alarm_hou,
	output logic   o_alarm,
	input  logic   clk,
	input  logic   rst_n
);

	localparam int DIV_W = $clog2(TICKS_PER_SEC);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICKS_PER_SEC - 1);

	logic [DIV_W-1:0] div_cnt;
	logic             tick;     // One-second strobe
	logic             sec_wrap;
	logic             min_wrap;
	logic             sec_adv;
	logic             min_adv;
	logic             hou_adv;
	logic             match;

	// Add one, back to zero past the limit
	function automatic hms_t step(input hms_t v, input hms_t lim);
		return (v >= lim) ? '0 : v + 6'd1;
	endfunction

	// ----------------------------
	// Seconds divider
	// ----------------------------
	assign tick = i_run && (div_cnt == DIV_LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			div_cnt <= '0;
		else if (tick)
			div_cnt <= '0;
		else if (i_run)
			div_cnt <= div_cnt + 1'b1;
	end

	// ----------------------------
	// Time counters
	// ----------------------------
	assign sec_wrap = tick && (o_sec == SEC_MAX);
	assign min_wrap = sec_wrap && (o_min == SEC_MAX);

	// Strobes step one field with no carry
	assign sec_adv = tick || i_time_inc[0];
	assign min_adv = sec_wrap || i_time_inc[1];
	assign hou_adv = min_wrap || i_time_inc[2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_sec <= '0;
			o_min <= '0;
			o_hou <= '0;
		end else begin
			if (sec_adv) o_sec <= step(o_sec, SEC_MAX);
			if (min_adv) o_min <= step(o_min, SEC_MAX);
			if (hou_adv) o_hou <= step(o_hou, HOU_MAX);
		end
	end

	// ----------------------------
	// Alarm counters and flag
	// ----------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm_sec <= '0;
			o_alarm_min <= '0;
			o_alarm_hou <= '0;
		end else begin
			if (i_alarm_inc[0]) o_alarm_sec <= step(o_alarm_sec, SEC_MAX);
			if (i_alarm_inc[1]) o_alarm_min <= step(o_alarm_min, SEC_MAX);
			if (i_alarm_inc[2]) o_alarm_hou <= step(o_alarm_hou, HOU_MAX);
		end
	end

	assign match = (o_sec == o_alarm_sec) && (o_min == o_alarm_min) && (o_hou == o_alarm_hou);

	// Sticky until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= i_alarm_en && (match || o_alarm);
	end

endmodule

// ==== clock_ctrl.sv ====
// ----------------------------
// Control stage
// Mode and position FSMs, alarm enable,
// increment routing and decimal point mask
// ----------------------------
module clock_ctrl import clock_pkg::*; (
	input  logic     i_mode_pulse,
	input  logic     i_pos_pulse,
	input  logic     i_inc_pulse,
	input  logic     i_alarm_pulse,
	output logic     o_run,
	output field_t   o_time_inc,
	output field_t   o_alarm_inc,
	output logic     o_alarm_en,
	output logic     o_show_alarm,
	output dp_mask_t o_dp_mask,
	input  logic     clk,
	input  logic     rst_n
);

	mode_e  mode;
	pos_e   pos;
	field_t pos_field; // Selected field as one-hot

	assign pos_field = field_t'(1) << pos;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode        <= MODE_CLOCK;
			pos         <= POS_SEC;
			o_alarm_en  <= 1'b0;
			o_time_inc  <= '0;
			o_alarm_inc <= '0;
		end else begin
			if (i_mode_pulse) begin
				case (mode)
					MODE_CLOCK: mode <= MODE_SETUP;
					MODE_SETUP: mode <= MODE_ALARM;
					default:    mode <= MODE_CLOCK;
				endcase
			end
			if (i_pos_pulse) begin
				case (pos)
					POS_SEC: pos <= POS_MIN;
					POS_MIN: pos <= POS_HOU;
					default: pos <= POS_SEC;
				endcase
			end
			if (i_alarm_pulse)
				o_alarm_en <= ~o_alarm_en;
			// Increment ignored in clock mode
			o_time_inc  <= (i_inc_pulse && mode == MODE_SETUP) ? pos_field : '0;
			o_alarm_inc <= (i_inc_pulse && mode == MODE_ALARM) ? pos_field : '0;
		end
	end

	assign o_run        = (mode != MODE_SETUP);
	assign o_show_alarm = (mode == MODE_ALARM);

	// Ones digit in setup, tens digit in alarm
	always_comb begin
		case (mode)
			MODE_SETUP: o_dp_mask = dp_mask_t'(1) << {pos, 1'b0};
			MODE_ALARM: o_dp_mask = dp_mask_t'(2) << {pos, 1'b0};
			default:    o_dp_mask = '0;
		endcase
	end

endmodule

// ==== btn_sync.sv ====
// ----------------------------
// Button input stage
// Two-flop synchronizers and rising-edge pulses
// for the mode, position, increment and alarm buttons
// ----------------------------
module btn_sync (
	input  logic i_btn_mode,
	input  logic i_btn_pos,
	input  logic i_btn_inc,
	input  logic i_btn_alarm,
	output logic o_mode_pulse,
	output logic o_pos_pulse,
	output logic o_inc_pulse,
	output logic o_alarm_pulse,
	input  logic clk,
	input  logic rst_n
);

	logic [3:0] btn_raw;
	logic [3:0] sync1;
	logic [3:0] sync2;
	logic [3:0] btn_q;  // Synchronized level, one cycle later
	logic [3:0] pulse;

	assign btn_raw = {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
			btn_q <= '0;
			pulse <= '0;
		end else begin
			sync1 <= btn_raw;
			sync2 <= sync1;
			btn_q <= sync2;
			pulse <= sync2 & ~btn_q; // One pulse per press
		end
	end

	assign o_mode_pulse  = pulse[0];
	assign o_pos_pulse   = pulse[1];
	assign o_inc_pulse   = pulse[2];
	assign o_alarm_pulse = pulse[3];

endmodule

// ==== clock_pkg.sv ====
// ----------------------------
// Clock package
// Field widths, counter limits, divider lengths,
// segment table and the mode and position enums
// ----------------------------
package clock_pkg;

	typedef logic [5:0] hms_t;       // One time field, 0..59
	typedef logic [3:0] bcd_t;       // One decimal digit
	typedef logic [6:0] seg_t;       // {a, b, c, d, e, f, g}, active high
	typedef logic [5:0] digit_sel_t; // Active-low digit enable
	typedef logic [5:0] dp_mask_t;   // Decimal point per digit
	typedef logic [2:0] field_t;     // {hou, min, sec} strobe

	typedef enum logic [1:0] {
		MODE_CLOCK,
		MODE_SETUP,
		MODE_ALARM
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC,
		POS_MIN,
		POS_HOU
	} pos_e;

	localparam hms_t SEC_MAX = 6'd59; // Also the minutes limit
	localparam hms_t HOU_MAX = 6'd23;

	// Scaled down for simulation
	localparam int TICKS_PER_SEC = 16;
	localparam int SCAN_TICKS    = 4;
	localparam int NUM_DIGITS    = 6;

	// Digit patterns 0..9
	localparam seg_t SEG_DIGIT [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

endpackage
